// ==== hw/cache_pkg.sv ====
////////////////////////////////////////
// data cache shared definitions
////////////////////////////////////////

package cache_pkg;

    // word-addressed backing store, 4096 words
    parameter int word_bits = 32;
    parameter int addr_bits = 12;

    typedef logic [word_bits-1:0] word_t;
    typedef logic [addr_bits-1:0] addr_t;

    // controller states
    typedef enum logic [2:0] {
        idle,
        lookup,
        write_back, // dirty victim out, one word per cycle
        fill,
        fill_drain, // last fill word returns
        finish
    } ctrl_state_t;

endpackage

// ==== hw/line_if.sv ====
////////////////////////////////////////
// controller to line array link
////////////////////////////////////////

interface line_if #(
    parameter int index_bits  = 4,
    parameter int offset_bits = 2
);
    localparam int tag_bits = cache_pkg::addr_bits - index_bits - offset_bits;

    logic [index_bits-1:0]  index;
    logic [offset_bits-1:0] offset;
    logic [tag_bits-1:0]    tag;
    logic                   word_write;   // request word into the line
    logic                   fill_write;   // returning memory word into the line
    logic [offset_bits-1:0] beat;
    logic                   set_line;
    logic                   read_capture;

    logic                   tag_match;
    logic                   victim_dirty;
    logic [tag_bits-1:0]    victim_tag;

    modport ctrl (
        output index, offset, tag, word_write, fill_write, beat, set_line, read_capture,
        input  tag_match, victim_dirty, victim_tag
    );

    modport lines (
        input  index, offset, tag, word_write, fill_write, beat, set_line, read_capture,
        output tag_match, victim_dirty, victim_tag
    );

endinterface

// ==== hw/mem_bus_if.sv ====
////////////////////////////////////////
// backing memory word bus
////////////////////////////////////////

interface mem_bus_if #(
    parameter int index_bits  = 4,
    parameter int offset_bits = 2
);
    logic             mem_we;
    cache_pkg::addr_t mem_addr;
    cache_pkg::word_t mem_wdata;
    cache_pkg::word_t mem_rdata; // one cycle after mem_addr

    // geometry must leave room for a tag field
    if (cache_pkg::addr_bits - index_bits - offset_bits < 1) begin : g_geometry_check
        $error("index_bits plus offset_bits leave no tag bits");
    end

    modport ctrl (output mem_addr, mem_we);
    modport data (output mem_wdata, input mem_rdata);
    modport mem  (input mem_addr, mem_we, mem_wdata, output mem_rdata);

endinterface

// ==== hw/beat_counter.sv ====
////////////////////////////////////////
// block transfer beat counter
////////////////////////////////////////

module beat_counter #(
    parameter int offset_bits = 2
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   clear,
    input  logic                   step,
    output logic [offset_bits-1:0] count,
    output logic                   last
);

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (step) begin
            count <= count + 1'b1; // wraps after the last word
        end
    end

    // final word of the line
    assign last = (count == {offset_bits{1'b1}});

endmodule

// ==== hw/cache_ctrl.sv ====
////////////////////////////////////////
// cache controller FSM
////////////////////////////////////////

module cache_ctrl #(
    parameter int index_bits  = 4,
    parameter int offset_bits = 2
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   req,
    input  logic                   we,
    input  cache_pkg::addr_t       addr,
    input  cache_pkg::word_t       wdata,
    output logic                   busy,
    output logic                   hit,
    output logic                   done,
    output cache_pkg::word_t       req_wdata,
    line_if.ctrl                   lb,
    mem_bus_if.ctrl                mb,
    output logic                   beat_clear,
    output logic                   beat_step,
    input  logic [offset_bits-1:0] beat_count,
    input  logic                   beat_last
);
    localparam int tag_bits = cache_pkg::addr_bits - index_bits - offset_bits;

    cache_pkg::ctrl_state_t state;
    cache_pkg::ctrl_state_t state_next;

    logic                   we_q;
    cache_pkg::addr_t       addr_q;
    logic                   first_lookup;
    logic                   first_hit;
    logic                   fill_pending; // fill word due on mem_rdata
    logic [offset_bits-1:0] fill_beat;
    logic                   accept;
    logic                   in_lookup;

    assign accept    = (state == cache_pkg::idle) && req;
    assign in_lookup = (state == cache_pkg::lookup);

    // address fields
    assign lb.offset = addr_q[offset_bits-1:0];
    assign lb.index  = addr_q[offset_bits +: index_bits];
    assign lb.tag    = addr_q[cache_pkg::addr_bits-1 -: tag_bits];

    assign lb.word_write   = in_lookup && lb.tag_match && we_q;
    assign lb.read_capture = in_lookup && lb.tag_match && !we_q;
    assign lb.set_line     = (state == cache_pkg::fill_drain);
    assign lb.fill_write   = fill_pending;
    assign lb.beat         = fill_pending ? fill_beat : beat_count;

    assign beat_clear = in_lookup;
    assign beat_step  = (state == cache_pkg::write_back) || (state == cache_pkg::fill);

    always_comb begin
        mb.mem_we   = 1'b0;
        mb.mem_addr = {lb.tag, lb.index, beat_count}; // fill address
        if (state == cache_pkg::write_back) begin
            mb.mem_we   = 1'b1;
            mb.mem_addr = {lb.victim_tag, lb.index, beat_count};
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            cache_pkg::idle:       if (req) state_next = cache_pkg::lookup;
            cache_pkg::lookup: begin
                if (lb.tag_match)
                    state_next = cache_pkg::finish;
                else if (lb.victim_dirty)
                    state_next = cache_pkg::write_back;
                else
                    state_next = cache_pkg::fill;
            end
            cache_pkg::write_back: if (beat_last) state_next = cache_pkg::fill;
            cache_pkg::fill:       if (beat_last) state_next = cache_pkg::fill_drain;
            cache_pkg::fill_drain: state_next = cache_pkg::lookup; // second lookup now hits
            cache_pkg::finish:     state_next = cache_pkg::idle;
            default:               state_next = cache_pkg::idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= cache_pkg::idle;
            first_lookup <= 1'b0;
            first_hit    <= 1'b0;
            fill_pending <= 1'b0;
        end else begin
            state        <= state_next;
            fill_pending <= (state == cache_pkg::fill);
            if (accept)
                first_lookup <= 1'b1;
            else if (in_lookup)
                first_lookup <= 1'b0;
            if (in_lookup && first_lookup)
                first_hit <= lb.tag_match;
        end
    end

    // request and beat payload
    always_ff @(posedge clk) begin
        if (accept) begin
            we_q      <= we;
            addr_q    <= addr;
            req_wdata <= wdata;
        end
        fill_beat <= beat_count;
    end

    assign busy = (state != cache_pkg::idle);
    assign done = (state == cache_pkg::finish);
    assign hit  = done && first_hit;

endmodule

// ==== hw/cache_lines.sv ====
////////////////////////////////////////
// cache line storage
////////////////////////////////////////

module cache_lines #(
    parameter int index_bits  = 4,
    parameter int offset_bits = 2
) (
    input  logic             clk,
    input  logic             reset,
    input  cache_pkg::word_t wdata,
    output cache_pkg::word_t rdata,
    line_if.lines            lb,
    mem_bus_if.data          mb
);
    localparam int tag_bits = cache_pkg::addr_bits - index_bits - offset_bits;
    localparam int lines    = 2 ** index_bits;
    localparam int words    = 2 ** offset_bits;

    cache_pkg::word_t    data_mem [lines*words]; // line-major, word offset in low bits
    logic [tag_bits-1:0] tag_mem  [lines];
    logic [lines-1:0]    valid;
    logic [lines-1:0]    dirty;

    logic [index_bits+offset_bits-1:0] req_word;
    logic [index_bits+offset_bits-1:0] beat_word;

    assign req_word  = {lb.index, lb.offset};
    assign beat_word = {lb.index, lb.beat};

    // lookup on the indexed line
    assign lb.tag_match    = valid[lb.index] && (tag_mem[lb.index] == lb.tag);
    assign lb.victim_dirty = valid[lb.index] && dirty[lb.index];
    assign lb.victim_tag   = tag_mem[lb.index];

    assign mb.mem_wdata = data_mem[beat_word]; // victim word for write-back

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= '0;
            dirty <= '0;
        end else begin
            if (lb.set_line) begin
                valid[lb.index] <= 1'b1;
                dirty[lb.index] <= 1'b0;
            end
            if (lb.word_write)
                dirty[lb.index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (lb.set_line)
            tag_mem[lb.index] <= lb.tag;
        if (lb.fill_write)
            data_mem[beat_word] <= mb.mem_rdata;
        if (lb.word_write)
            data_mem[req_word] <= wdata;
    end

    always_ff @(posedge clk) begin
        if (lb.read_capture)
            rdata <= data_mem[req_word];
    end

endmodule

// ==== hw/backing_memory.sv ====
////////////////////////////////////////
// backing word RAM
////////////////////////////////////////

module backing_memory (
    input  logic   clk,
    mem_bus_if.mem mb
);
    localparam int depth = 2 ** cache_pkg::addr_bits;

    cache_pkg::word_t ram [depth];

    // power-up contents
    initial begin
        for (int i = 0; i < depth; i++) begin
            ram[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (mb.mem_we)
            ram[mb.mem_addr] <= mb.mem_wdata;
        mb.mem_rdata <= ram[mb.mem_addr]; // read data one edge later
    end

endmodule

// ==== hw/data_cache_top.sv ====
////////////////////////////////////////
// write-back data cache top
////////////////////////////////////////

module data_cache_top #(
    parameter int index_bits  = 4, // 16 lines
    parameter int offset_bits = 2  // 4 words per line
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             req,
    input  logic             we,
    input  cache_pkg::addr_t addr,
    input  cache_pkg::word_t wdata,
    output logic             busy,
    output cache_pkg::word_t rdata,
    output logic             hit,
    output logic             done
);

    line_if    #(.index_bits(index_bits), .offset_bits(offset_bits)) i_line ();
    mem_bus_if #(.index_bits(index_bits), .offset_bits(offset_bits)) i_mem_bus ();

    logic                   beat_clear;
    logic                   beat_step;
    logic                   beat_last;
    logic [offset_bits-1:0] beat_count;
    cache_pkg::word_t       req_wdata;

    cache_ctrl #(.index_bits(index_bits), .offset_bits(offset_bits)) i_ctrl (
        .clk, .reset, .req, .we, .addr, .wdata,
        .busy, .hit, .done, .req_wdata,
        .lb(i_line.ctrl), .mb(i_mem_bus.ctrl),
        .beat_clear, .beat_step, .beat_count, .beat_last
    );

    cache_lines #(.index_bits(index_bits), .offset_bits(offset_bits)) i_lines (
        .clk, .reset, .wdata(req_wdata), .rdata,
        .lb(i_line.lines), .mb(i_mem_bus.data)
    );

    beat_counter #(.offset_bits(offset_bits)) i_beat (
        .clk, .reset, .clear(beat_clear), .step(beat_step),
        .count(beat_count), .last(beat_last)
    );

    backing_memory i_memory (.clk, .mb(i_mem_bus.mem));

endmodule

// ==== sim/cache_props.sv ====
////////////////////////////////////////
// controller assertions
////////////////////////////////////////

module cache_props (
    input logic                   clk,
    input logic                   reset,
    input logic                   busy,
    input logic                   done,
    input logic                   mem_we,
    input cache_pkg::ctrl_state_t state
);
    timeunit 1ns;
    timeprecision 100ps;

    int failures = 0;

    done_pulse: assert property (@(posedge clk) disable iff (reset) done |=> !done)
        else begin
            failures++;
            $error("done high for two cycles in a row");
        end

    // memory writes come only from victim write-back
    we_in_write_back: assert property (@(posedge clk) disable iff (reset)
        mem_we |-> state == cache_pkg::write_back)
        else begin
            failures++;
            $error("mem_we high outside write_back");
        end

    idle_after_reset: assert property (@(posedge clk) reset |=> !busy)
        else begin
            failures++;
            $error("busy high in the cycle after reset");
        end

endmodule

bind cache_ctrl cache_props i_props (
    .clk(clk), .reset(reset), .busy(busy), .done(done),
    .mem_we(mb.mem_we), .state(state)
);

// ==== sim/cache_checker.sv ====
////////////////////////////////////////
// cache reference model and checker
////////////////////////////////////////

module cache_checker #(
    parameter int index_bits  = 4,
    parameter int offset_bits = 2
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             req,
    input  logic             we,
    input  cache_pkg::addr_t addr,
    input  cache_pkg::word_t wdata,
    input  logic             busy,
    input  cache_pkg::word_t rdata,
    input  logic             hit,
    input  logic             done,
    output int               errors
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int tag_bits = cache_pkg::addr_bits - index_bits - offset_bits;

    cache_pkg::word_t         mem_model [2**cache_pkg::addr_bits]; // latest value per word
    logic [tag_bits-1:0]      tag_mirror [2**index_bits];
    logic [2**index_bits-1:0] valid_mirror;

    logic             idle_seen = 1'b0; // busy as seen at the last falling edge
    logic             pending = 1'b0;
    int               reset_edges = 0;
    logic             exp_we;
    logic             exp_hit;
    cache_pkg::addr_t exp_addr;
    cache_pkg::word_t exp_rdata;

    initial begin
        errors = 0;
        foreach (mem_model[i])
            mem_model[i] = '0;
    end

    // request accepted on a rising edge while idle
    always @(posedge clk) begin : model_update
        logic [index_bits-1:0] idx;
        logic [tag_bits-1:0]   tag;
        if (reset) begin
            reset_edges++;
            valid_mirror = '0;
            pending = 1'b0;
        end else if (req && idle_seen) begin
            idx = addr[offset_bits +: index_bits];
            tag = addr[cache_pkg::addr_bits-1 -: tag_bits];
            exp_hit = valid_mirror[idx] && (tag_mirror[idx] == tag);
            exp_we = we;
            exp_addr = addr;
            exp_rdata = mem_model[addr];
            if (we)
                mem_model[addr] = wdata;
            valid_mirror[idx] = 1'b1; // miss or hit, line now holds this tag
            tag_mirror[idx] = tag;
            pending = 1'b1;
        end
    end

    always @(negedge clk) begin
        idle_seen = (busy === 1'b0);
        if (reset) begin
            if (reset_edges > 0 && (busy !== 1'b0 || done !== 1'b0)) begin
                $display("busy or done not low during reset");
                errors++;
            end
        end else if (reset_edges > 0) begin
            // busy from accept through the done cycle
            if (busy !== pending) begin
                $display("[FAIL] busy: got %h expected %h", busy, pending);
                errors++;
            end
            if (done === 1'b1) begin
                if (!pending) begin
                    $display("done pulse with no request outstanding");
                    errors++;
                end else begin
                    if (hit !== exp_hit) begin
                        $display("[FAIL] hit addr=%h: got %h expected %h",
                                 exp_addr, hit, exp_hit);
                        errors++;
                    end
                    if (!exp_we && rdata !== exp_rdata) begin
                        $display("[FAIL] rdata addr=%h: got %h expected %h",
                                 exp_addr, rdata, exp_rdata);
                        errors++;
                    end
                end
                pending = 1'b0;
            end
        end
    end

endmodule

// ==== sim/tb_data_cache.sv ====
////////////////////////////////////////
// data cache testbench
////////////////////////////////////////

module tb_data_cache;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int index_bits   = 4;
    localparam int offset_bits  = 2;
    localparam int clk_period   = 20;
    localparam int reset_cycles = 4;
    localparam int num_directed = 10;
    localparam int num_random   = 400;
    localparam int max_wait     = 20; // cycles from request to done
    localparam int worst_miss   = 14; // accept, two lookups, write-back, fill, drain, finish
    localparam int timeout_cycles = (num_directed + num_random) * worst_miss + reset_cycles + 50;

    logic             clk = 1'b0;
    logic             reset;
    logic             req;
    logic             we;
    logic             busy;
    logic             hit;
    logic             done;
    cache_pkg::addr_t addr;
    cache_pkg::word_t wdata;
    cache_pkg::word_t rdata;
    int               seed = 10;
    int               tb_errors = 0;
    int               model_errors;
    int               assert_errors;

    data_cache_top #(.index_bits(index_bits), .offset_bits(offset_bits)) i_dut (
        .clk, .reset, .req, .we, .addr, .wdata, .busy, .rdata, .hit, .done
    );

    cache_checker #(.index_bits(index_bits), .offset_bits(offset_bits)) i_checker (
        .clk, .reset, .req, .we, .addr, .wdata, .busy, .rdata, .hit, .done,
        .errors(model_errors)
    );

    initial begin
        forever #(clk_period / 2) clk = ~clk;
    end

    // one request, optionally with an extra req pulse while busy
    task automatic run_request(input logic w, input cache_pkg::addr_t a,
                               input cache_pkg::word_t d, input logic stray);
        int cycles;
        cycles = 0;
        while (busy)
            @(negedge clk);
        req = 1'b1;
        we = w;
        addr = a;
        wdata = d;
        @(negedge clk);
        req = stray;
        if (stray) begin
            we = ~w;
            addr = cache_pkg::addr_t'($random(seed));
            wdata = $random(seed);
            @(negedge clk);
            req = 1'b0;
        end
        while (done !== 1'b1 && cycles < max_wait) begin
            @(negedge clk);
            cycles++;
        end
        if (done !== 1'b1) begin
            $display("no done pulse within %0d cycles of the request to %h", max_wait, a);
            tb_errors++;
        end
        @(negedge clk);
    endtask

    task automatic random_request();
        logic [31:0] r;
        r = $random(seed);
        // four tags over four lines, 64 words
        run_request(r[6], {4'b0101, r[5:4], 2'b00, r[3:2], r[1:0]}, $random(seed), r[7] & r[8]);
    endtask

    initial begin
        reset = 1'b1;
        req = 1'b0;
        we = 1'b0;
        addr = '0;
        wdata = '0;
        repeat (reset_cycles) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        run_request(1'b0, 12'h123, '0, 1'b0); // cold miss, reads zero
        run_request(1'b0, 12'h123, '0, 1'b0);
        run_request(1'b1, 12'h045, 32'h1234_5678, 1'b0);
        run_request(1'b0, 12'h045, '0, 1'b0);
        run_request(1'b1, 12'h123, 32'h0bad_f00d, 1'b1);
        run_request(1'b0, 12'h123, '0, 1'b0);
        // dirty line at index 9 pushed out by another tag
        run_request(1'b1, 12'h0a4, 32'h5a5a_a5a5, 1'b0);
        run_request(1'b0, 12'h1a4, '0, 1'b1);
        run_request(1'b0, 12'h0a4, '0, 1'b0);
        run_request(1'b0, 12'h0a7, '0, 1'b0);
        repeat (num_random)
            random_request();
        repeat (4) @(negedge clk);
        assert_errors = i_dut.i_ctrl.i_props.failures;
        $display("errors: checker %0d, testbench %0d, assertions %0d",
                 model_errors, tb_errors, assert_errors);
        if (model_errors + tb_errors + assert_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(timeout_cycles * clk_period);
        $display("run timed out after %0d cycles before the tests finished", timeout_cycles);
        $display("Checks failed");
        $finish;
    end

endmodule

// ==== verilog.f ====
hw/cache_pkg.sv
hw/line_if.sv
hw/mem_bus_if.sv
hw/beat_counter.sv
hw/cache_ctrl.sv
hw/cache_lines.sv
hw/backing_memory.sv
hw/data_cache_top.sv
sim/cache_props.sv
sim/cache_checker.sv
sim/tb_data_cache.sv
